// ==== project.f ====
+incdir+design
design/pathOramPkg.sv
design/bucketHeaderGen.sv
design/dramInitializer.sv
design/dramCommandArbiter.sv
design/dramInitTop.sv
verif/dramInitTb.sv

// ==== Bender.yml ====
package:
  name: path_oram_dram_init

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pathOramPkg.sv
      - design/bucketHeaderGen.sv
      - design/dramInitializer.sv
      - design/dramCommandArbiter.sv
      - design/dramInitTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/dramInitTb.sv

// ==== verif/dramInitTb.sv ====
//------------------------------
// Self-checking testbench for the DRAM start-up stage
// Random DRAM ready and backend traffic, checked against a model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pathOram_macros.svh"

module dramInitTb
	import pathOramPkg::*;
;

	localparam int TimeoutCycles = 20 * `ORAM_N + 2000;
	localparam int BackendCycles = 500;
	localparam logic [31:0] RandSeed = 32'hc520be85;
	// Galois mask for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] RandTaps = 32'h80200003;

	logic clock;
	logic rstN;
	dramCmd_t beCmd;
	logic beCmdValid;
	logic beCmdReady;
	dramWrite_t beWr;
	logic beWrValid;
	logic beWrReady;
	dramCmd_t dramCmd;
	logic dramCmdValid;
	logic dramCmdReady;
	dramWrite_t dramWr;
	logic dramWrValid;
	logic dramWrReady;
	logic initDone;
	logic earlyRequest;

	// Random source state
	logic [31:0] lfsrState;
	int cycleCount;

	//------------------------------
	// Reference model state
	//------------------------------

	int cmdCount;
	int wrCount;
	iv_t ivModel;
	// Last cycle's stall, for the hold check
	logic cmdStalled;
	logic wrStalled;
	dramCmd_t lastCmd;
	dramWrite_t lastWr;
	logic doneExpected;
	logic sawDone;
	logic earlyPending;

	dramInitTop DUT (
		.clock(clock),
		.rstN(rstN),
		.beCmd(beCmd),
		.beCmdValid(beCmdValid),
		.beCmdReady(beCmdReady),
		.beWr(beWr),
		.beWrValid(beWrValid),
		.beWrReady(beWrReady),
		.dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramWr(dramWr),
		.dramWrValid(dramWrValid),
		.dramWrReady(dramWrReady),
		.initDone(initDone),
		.earlyRequest(earlyRequest)
	);

	// 8 ns clock
	always #4 clock = ~clock;

	// One LFSR step per bit taken, LSB first
	function automatic logic [71:0] randomBits(input int count);
		logic [71:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits[i] = lfsrState[0];
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ RandTaps : lfsrState >> 1;
		end
		return bits;
	endfunction

	// Header IV sequence, taps folded in when a one shifts out
	function automatic iv_t nextIv(input iv_t iv);
		return (iv >> 1) ^ ({`IV_WIDTH{iv[0]}} & iv_t'(`IV_TAPS));
	endfunction

	// IV in the top field and again below the four valid bits
	function automatic ddrData_t headerFor(input iv_t iv);
		ddrData_t word;
		word = '0;
		word[`DDR_D_WIDTH-1 -: `IV_WIDTH] = iv;
		word[`DDR_D_WIDTH-`IV_WIDTH-`VALID_BITS-1 -: `IV_WIDTH] = iv;
		return word;
	endfunction

	task automatic checkEqual(input logic [71:0] expected, input logic [71:0] actual,
			input string what);
		if (expected !== actual) begin
			$display("Mismatch at %0t ns: %s, expected %0h, got %0h",
				$time, what, expected, actual);
			$display("test failed");
			$fatal(1, "Stopped on first mismatch");
		end
	endtask

	// Ready about 5 in 8 high
	task automatic driveRandom();
		dramCmdReady <= (randomBits(3) < 5);
		dramWrReady <= (randomBits(3) < 5);
		beCmdValid <= randomBits(1);
		beCmd <= dramCmd_t'(randomBits($bits(dramCmd_t)));
		beWrValid <= randomBits(1);
		beWr <= dramWrite_t'(randomBits($bits(dramWrite_t)));
	endtask

	//------------------------------
	// Run limit
	//------------------------------

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Run timed out after %0d cycles before finishing", cycleCount);
			$display("test failed");
			$fatal(1, "Timeout");
		end
	end

	//------------------------------
	// Monitor, samples at the falling edge
	//------------------------------

	always @(negedge clock) begin
		if (rstN) begin
			if (doneExpected) checkEqual(1, initDone, "initDone late after last transfer");
			if (sawDone) checkEqual(1, initDone, "initDone dropped");
			if (earlyPending) begin
				checkEqual(1, earlyRequest, "earlyRequest not set");
			end else begin
				checkEqual(0, earlyRequest, "earlyRequest set with no backend request");
			end
			if (initDone) begin
				checkEqual(`ORAM_N, cmdCount, "initDone before all commands");
				checkEqual(`ORAM_N, wrCount, "initDone before all headers");
				sawDone = 1'b1;
				// Backend straight through
				checkEqual(beCmd, dramCmd, "command not passed through");
				checkEqual(beCmdValid, dramCmdValid, "command valid not passed through");
				checkEqual(beWr, dramWr, "write data not passed through");
				checkEqual(beWrValid, dramWrValid, "write valid not passed through");
				checkEqual(dramCmdReady, beCmdReady, "command ready not passed back");
				checkEqual(dramWrReady, beWrReady, "write ready not passed back");
			end else begin
				// Backend locked out
				checkEqual(0, beCmdReady, "backend command ready before done");
				checkEqual(0, beWrReady, "backend write ready before done");
				if (cmdStalled) begin
					checkEqual(1, dramCmdValid, "command valid dropped while stalled");
					checkEqual(lastCmd, dramCmd, "command changed while stalled");
				end
				if (wrStalled) begin
					checkEqual(1, dramWrValid, "write valid dropped while stalled");
					checkEqual(lastWr, dramWr, "write data changed while stalled");
				end
				if (cmdCount == `ORAM_N) begin
					checkEqual(0, dramCmdValid, "command valid after last bucket");
					checkEqual(`ORAM_N * `BKT_DDR_WORDS, dramCmd.addr, "final address");
				end
				if (wrCount == `ORAM_N) checkEqual(0, dramWrValid, "write valid after last header");
				// Transfers happen on the coming edge
				if (dramCmdValid && dramCmdReady) begin
					checkEqual(`DDR_CMD_WRITE, dramCmd.cmd, "command code");
					checkEqual(cmdCount * `BKT_DDR_WORDS, dramCmd.addr, "bucket address");
					cmdCount++;
				end
				if (dramWrValid && dramWrReady) begin
					checkEqual(headerFor(ivModel), dramWr.data, "header word");
					checkEqual(0, dramWr.mask, "header mask");
					ivModel = nextIv(ivModel);
					wrCount++;
				end
				if (cmdCount == `ORAM_N && wrCount == `ORAM_N) doneExpected = 1'b1;
				cmdStalled = dramCmdValid && !dramCmdReady;
				wrStalled = dramWrValid && !dramWrReady;
				lastCmd = dramCmd;
				lastWr = dramWr;
				if (beCmdValid) earlyPending = 1'b1;
			end
		end
	end

	//------------------------------
	// Main sequence
	//------------------------------

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		beCmd = '0;
		beCmdValid = 1'b0;
		beWr = '0;
		beWrValid = 1'b0;
		dramCmdReady = 1'b0;
		dramWrReady = 1'b0;
		lfsrState = RandSeed;
		cycleCount = 0;
		cmdCount = 0;
		wrCount = 0;
		ivModel = iv_t'(`IV_SEED);
		cmdStalled = 1'b0;
		wrStalled = 1'b0;
		lastCmd = '0;
		lastWr = '0;
		doneExpected = 1'b0;
		sawDone = 1'b0;
		earlyPending = 1'b0;

		repeat (10) @(posedge clock);
		rstN <= 1'b1;

		// Init phase, runs until done
		do begin
			@(posedge clock);
			driveRandom();
			@(negedge clock);
		end while (!initDone);

		// Backend phase
		repeat (BackendCycles) begin
			@(posedge clock);
			driveRandom();
		end
		// Monitor finishes the last cycle first
		@(negedge clock);
		@(posedge clock);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/dramInitTop.sv ====
//------------------------------
// DRAM start-up stage, bucket header init in front of the ORAM backend
// Sits between the backend and the DDR memory controller
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module dramInitTop
	import pathOramPkg::*;
(
	input wire logic clock,
	input wire logic rstN,

	// Backend channels
	input wire dramCmd_t beCmd,
	input wire logic beCmdValid,
	output logic beCmdReady,
	input wire dramWrite_t beWr,
	input wire logic beWrValid,
	output logic beWrReady,

	// DRAM channels
	output dramCmd_t dramCmd,
	output logic dramCmdValid,
	input wire logic dramCmdReady,
	output dramWrite_t dramWr,
	output logic dramWrValid,
	input wire logic dramWrReady,

	// Status
	output logic initDone,
	output logic earlyRequest
);

	//------------------------------
	// Internal wires
	//------------------------------

	ddrData_t header;
	logic headerTaken;

	// Initializer to arbiter
	dramCmd_t initCmd;
	logic initCmdValid;
	logic initCmdReady;
	dramWrite_t initWr;
	logic initWrValid;
	logic initWrReady;

	//------------------------------
	// Blocks
	//------------------------------

	// IV source for each header
	bucketHeaderGen headerGen (
		.clock(clock),
		.rstN(rstN),
		.headerTaken(headerTaken),
		.header(header)
	);

	dramInitializer initializer (
		.clock(clock),
		.rstN(rstN),
		.header(header),
		.headerTaken(headerTaken),
		.cmd(initCmd),
		.cmdValid(initCmdValid),
		.cmdReady(initCmdReady),
		.wrData(initWr),
		.wrValid(initWrValid),
		.wrReady(initWrReady),
		.done(initDone)
	);

	// Hands DRAM to the backend once done
	dramCommandArbiter arbiter (
		.clock(clock),
		.rstN(rstN),
		.done(initDone),
		.initCmd(initCmd),
		.initCmdValid(initCmdValid),
		.initCmdReady(initCmdReady),
		.initWr(initWr),
		.initWrValid(initWrValid),
		.initWrReady(initWrReady),
		.beCmd(beCmd),
		.beCmdValid(beCmdValid),
		.beCmdReady(beCmdReady),
		.beWr(beWr),
		.beWrValid(beWrValid),
		.beWrReady(beWrReady),
		.dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramWr(dramWr),
		.dramWrValid(dramWrValid),
		.dramWrReady(dramWrReady),
		.earlyRequest(earlyRequest)
	);

endmodule

`default_nettype wire

// ==== design/dramCommandArbiter.sv ====
//------------------------------
// DRAM port owner select, initializer first, then the ORAM backend
// Purely combinational data paths, no added latency
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module dramCommandArbiter
	import pathOramPkg::*;
(
	input wire logic clock,
	input wire logic rstN,

	// Initialization finished, backend owns DRAM
	input wire logic done,

	// Initializer side
	input wire dramCmd_t initCmd,
	input wire logic initCmdValid,
	output logic initCmdReady,
	input wire dramWrite_t initWr,
	input wire logic initWrValid,
	output logic initWrReady,

	// Backend side
	input wire dramCmd_t beCmd,
	input wire logic beCmdValid,
	output logic beCmdReady,
	input wire dramWrite_t beWr,
	input wire logic beWrValid,
	output logic beWrReady,

	// DRAM side
	output dramCmd_t dramCmd,
	output logic dramCmdValid,
	input wire logic dramCmdReady,
	output dramWrite_t dramWr,
	output logic dramWrValid,
	input wire logic dramWrReady,

	// Backend asked for DRAM too soon
	output logic earlyRequest
);

	// Cycles of backend command valid seen before done
	logic [3:0] earlyCount;

	//------------------------------
	// Port select
	//------------------------------

	// Owner valid and payload go straight to DRAM
	assign dramCmd = done ? beCmd : initCmd;
	assign dramCmdValid = done ? beCmdValid : initCmdValid;
	assign dramWr = done ? beWr : initWr;
	assign dramWrValid = done ? beWrValid : initWrValid;

	// DRAM ready back to the owner only
	assign initCmdReady = ~done & dramCmdReady;
	assign initWrReady = ~done & dramWrReady;
	assign beCmdReady = done & dramCmdReady;
	assign beWrReady = done & dramWrReady;

	//------------------------------
	// Early request monitor
	//------------------------------

	// Saturates at all ones
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			earlyCount <= '0;
		end else if (!done && beCmdValid && earlyCount != '1) begin
			earlyCount <= earlyCount + 4'd1;
		end
	end

	// Sticky, count never falls back to zero
	assign earlyRequest = (earlyCount != '0);

endmodule

`default_nettype wire

// ==== design/dramInitializer.sv ====
//------------------------------
// Writes a fresh header into every bucket after DDR calibration
// Drives both DRAM channels until done rises
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pathOram_macros.svh"

module dramInitializer
	import pathOramPkg::*;
(
	input wire logic clock,
	input wire logic rstN,

	// Header word for the next bucket
	input wire ddrData_t header,
	// Strobe on each header transfer
	output logic headerTaken,

	// Command channel
	output dramCmd_t cmd,
	output logic cmdValid,
	input wire logic cmdReady,

	// Write-data channel
	output dramWrite_t wrData,
	output logic wrValid,
	input wire logic wrReady,

	// Every bucket written
	output logic done
);

	// First address past the last bucket
	localparam ddrAddr_t EndOfTreeAddr = ddrAddr_t'(`ORAM_N * `BKT_DDR_WORDS);
	localparam ddrAddr_t BucketStride = ddrAddr_t'(`BKT_DDR_WORDS);
	localparam bktIdx_t LastHeader = bktIdx_t'(`ORAM_N);

	// Base address of the next bucket command
	ddrAddr_t cmdAddr;
	ddrAddr_t cmdAddrNext;
	// Header words sent so far
	bktIdx_t wrCount;
	bktIdx_t wrCountNext;

	logic cmdFire;
	logic wrFire;

	//------------------------------
	// Handshakes
	//------------------------------

	// Channels step on their own
	assign cmdFire = cmdValid & cmdReady;
	assign wrFire = wrValid & wrReady;
	assign headerTaken = wrFire;

	// Valid holds until the counter reaches its end
	assign cmdValid = (cmdAddr != EndOfTreeAddr);
	assign wrValid = (wrCount != LastHeader);

	//------------------------------
	// Counters
	//------------------------------

	assign cmdAddrNext = cmdFire ? cmdAddr + BucketStride : cmdAddr;
	assign wrCountNext = wrFire ? wrCount + bktIdx_t'(1) : wrCount;

	// Done registered from next state, so it follows the later final transfer
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			cmdAddr <= '0;
			wrCount <= '0;
			done <= 1'b0;
		end else begin
			cmdAddr <= cmdAddrNext;
			wrCount <= wrCountNext;
			done <= (cmdAddrNext == EndOfTreeAddr) && (wrCountNext == LastHeader);
		end
	end

	//------------------------------
	// Payloads
	//------------------------------

	// Every command is a bucket write
	assign cmd.addr = cmdAddr;
	assign cmd.cmd = ddrCmd_t'(`DDR_CMD_WRITE);

	// Mask of zeros writes all bytes
	assign wrData.data = header;
	assign wrData.mask = '0;

endmodule

`default_nettype wire

// ==== design/bucketHeaderGen.sv ====
//------------------------------
// Bucket header word source for tree initialization
// Pulse headerTaken once per header consumed
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pathOram_macros.svh"

module bucketHeaderGen
	import pathOramPkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	// Current header accepted downstream
	input wire logic headerTaken,
	output ddrData_t header
);

	// Zero fill below the second IV copy
	localparam int PadWidth = `DDR_D_WIDTH - 2 * `IV_WIDTH - `VALID_BITS;

	// IV of the header now on offer
	iv_t iv;
	// LFSR state after one step
	iv_t ivNext;

	//------------------------------
	// IV LFSR
	//------------------------------

	// Galois form, shift right and fold taps on a one out
	always_comb begin
		if (iv[0]) begin
			ivNext = (iv >> 1) ^ iv_t'(`IV_TAPS);
		end else begin
			ivNext = iv >> 1;
		end
	end

	// Hold while the write channel stalls
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			iv <= iv_t'(`IV_SEED);
		end else if (headerTaken) begin
			iv <= ivNext;
		end
	end

	//------------------------------
	// Header layout
	//------------------------------

	// IV, cleared valid bits, IV copy, zero pad
	assign header = {iv, {`VALID_BITS{1'b0}}, iv, {PadWidth{1'b0}}};

endmodule

`default_nettype wire

// ==== design/pathOramPkg.sv ====
//------------------------------
// Types for the DRAM start-up stage
// Import into any module that carries DDR traffic
//------------------------------
`default_nettype none

`include "pathOram_macros.svh"

package pathOramPkg;

	//------------------------------
	// Plain vectors
	//------------------------------

	// DDR word address
	typedef logic [`DDR_A_WIDTH-1:0] ddrAddr_t;
	// DDR command code
	typedef logic [`DDR_C_WIDTH-1:0] ddrCmd_t;
	// One DDR data word
	typedef logic [`DDR_D_WIDTH-1:0] ddrData_t;
	// Byte mask, a 0 bit writes that byte
	typedef logic [`DDR_M_WIDTH-1:0] ddrMask_t;
	// Bucket index, one bit extra so ORAM_N itself fits
	typedef logic [$clog2(`ORAM_N + 1)-1:0] bktIdx_t;
	// Initialization vector in a bucket header
	typedef logic [`IV_WIDTH-1:0] iv_t;

	//------------------------------
	// Channel payloads
	//------------------------------

	// Command channel, address above code
	typedef struct packed {
		ddrAddr_t addr;
		ddrCmd_t cmd;
	} dramCmd_t;

	// Write-data channel, data above mask
	typedef struct packed {
		ddrData_t data;
		ddrMask_t mask;
	} dramWrite_t;

endpackage

`default_nettype wire

// ==== design/pathOram_macros.svh ====
//------------------------------
// Sizes, widths and codes shared by the DRAM start-up stage
// Include wherever a size or a code is needed
//------------------------------
`ifndef PATHORAM_MACROS_SVH
`define PATHORAM_MACROS_SVH

//------------------------------
// Tree geometry
//------------------------------

// Buckets in the ORAM tree
`define ORAM_N 16
// DDR words per bucket, also the bucket address stride
`define BKT_DDR_WORDS 4

//------------------------------
// DDR port widths
//------------------------------

`define DDR_A_WIDTH 28
`define DDR_D_WIDTH 64
// One mask bit per data byte
`define DDR_M_WIDTH 8
`define DDR_C_WIDTH 3

// Command codes as seen by the memory controller
`define DDR_CMD_WRITE 0
`define DDR_CMD_READ 1

//------------------------------
// Bucket header fields
//------------------------------

`define IV_WIDTH 16
// One valid bit per block slot
`define VALID_BITS 4
// LFSR start value, must not be zero
`define IV_SEED 16'hACE1
// Galois feedback mask for x^16 + x^14 + x^13 + x^11 + 1
`define IV_TAPS 16'hB400

`endif
